// ==== Bender.yml ====
package:
  name: eeprom_subsystem

sources:
  - hdl/eeprom_pkg.sv
  - hdl/eeprom_bus_arbiter.sv
  - hdl/eeprom_txn_engine.sv
  - hdl/eeprom_bit_phy.sv
  - hdl/eeprom_subsystem.sv
  - target: simulation
    files:
      - dv/eeprom_model.sv
      - dv/eeprom_checker.sv
      - dv/eeprom_tb.sv

// ==== build.f ====
hdl/eeprom_pkg.sv
hdl/eeprom_bus_arbiter.sv
hdl/eeprom_txn_engine.sv
hdl/eeprom_bit_phy.sv
hdl/eeprom_subsystem.sv
dv/eeprom_model.sv
dv/eeprom_checker.sv
dv/eeprom_tb.sv

// ==== dv/eeprom_checker.sv ====
`timescale 1ns/1ns
module eeprom_checker (
    input logic                   CLK,
    input logic                   RESET,
    input eeprom_pkg::txn_state_e state,
    input logic                   go,
    input logic                   scl,
    input logic                   sda_drive_low,
    input logic                   ack_a,
    input logic                   ack_b
);
    import eeprom_pkg::*;

    int fail_count = 0;

    // bus released whenever no transfer runs
    bus_idle_level: assert property (@(posedge CLK) disable iff (RESET)
        state == st_idle |-> scl && !sda_drive_low)
        else begin
            $error("bus not released while the engine is idle");
            fail_count++;
        end

    ack_a_single: assert property (@(posedge CLK) disable iff (RESET)
        ack_a |=> !ack_a)
        else begin
            $error("ack_a high on two cycles in a row");
            fail_count++;
        end

    ack_b_single: assert property (@(posedge CLK) disable iff (RESET)
        ack_b |=> !ack_b)
        else begin
            $error("ack_b high on two cycles in a row");
            fail_count++;
        end

    // one ack per granted transfer before the next grant
    ack_before_next_go: assert property (@(posedge CLK) disable iff (RESET)
        go |=> !go throughout (ack_a || ack_b) [->1])
        else begin
            $error("new transfer granted before the previous one was acked");
            fail_count++;
        end

endmodule

bind eeprom_subsystem eeprom_checker checker_i (
    .CLK           (CLK),
    .RESET         (RESET),
    .state         (engine_i.state),
    .go            (go),
    .scl           (scl),
    .sda_drive_low (sda_drive_low),
    .ack_a         (ack_a),
    .ack_b         (ack_b)
);

// ==== dv/eeprom_model.sv ====
`timescale 1ns/1ns
module eeprom_model (
    input wire scl,
    inout wire sda
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        m_idle,
        m_ctrl,
        m_addr,
        m_wdata,
        m_rdata
    } model_state_e;

    eeprom_byte_t mem [0:2047];
    model_state_e state;
    model_state_e next_state;
    eeprom_addr_t ptr;
    eeprom_byte_t shift;
    logic [3:0]   cnt;       // finished bits in this frame
    logic         got_bit;   // a rising scl was seen since the last fall
    logic         sda_low;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'hFF;
        end
        state      = m_idle;
        next_state = m_idle;
        ptr        = '0;
        shift      = '0;
        cnt        = '0;
        got_bit    = 1'b0;
        sda_low    = 1'b0;
    end

    // ack or nack decision at the end of a received byte
    task automatic take_byte();
        sda_low    = 1'b1;
        next_state = m_idle;
        case (state)
            m_ctrl: begin
                if (shift[7:4] != 4'b1010) begin
                    sda_low = 1'b0;   // not our device code
                end else begin
                    ptr[10:8]  = shift[3:1];
                    next_state = shift[0] ? m_rdata : m_addr;
                end
            end
            m_addr: begin
                ptr[7:0]   = shift;
                next_state = m_wdata;
            end
            default: begin
                if (ptr >= 11'h700) begin
                    sda_low = 1'b0;   // top page write protected
                end else begin
                    mem[ptr] = shift;
                end
            end
        endcase
    endtask

    always @(negedge sda) begin
        if (scl === 1'b1) begin   // start or repeated start
            state   = m_ctrl;
            cnt     = 4'd0;
            got_bit = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            state = m_idle;   // stop
        end
    end

    always @(posedge scl) begin
        if (state != m_idle) begin
            got_bit = 1'b1;
            if (state != m_rdata && cnt < 4'd8) begin
                shift = {shift[6:0], sda};
            end
        end
    end

    always @(negedge scl) begin
        if (state != m_idle && got_bit) begin
            got_bit = 1'b0;
            if (cnt == 4'd8) begin
                cnt     = 4'd0;
                sda_low = 1'b0;
                state   = next_state;
                if (state == m_rdata) begin
                    shift      = mem[ptr];
                    sda_low    = !shift[7];
                    next_state = m_idle;   // single byte reads only
                end
            end else begin
                cnt = cnt + 4'd1;
                if (state == m_rdata) begin
                    sda_low = (cnt < 4'd8) && !shift[3'd7 - cnt[2:0]];
                end else if (cnt == 4'd8) begin
                    take_byte();
                end
            end
        end
    end

endmodule

// ==== dv/eeprom_tb.sv ====
`timescale 1ns/1ns
module eeprom_tb;
    import eeprom_pkg::*;

    localparam int SCL_QUARTER = 2;
    localparam int N_RANDOM    = 30;

    typedef struct packed {
        logic         port;       // 0 is port a
        eeprom_op_e   op;
        eeprom_addr_t addr;
        eeprom_byte_t wdata;
        logic         simul;      // strobed in the same cycle as the next entry
        logic         shadow;     // expected values come from the shadow memory
        eeprom_byte_t exp_rdata;
        logic         exp_nack;
    } entry_t;

    logic         CLK;
    logic         RESET;
    logic         wr_a;
    logic         rd_a;
    eeprom_addr_t addr_a;
    eeprom_byte_t wdata_a;
    logic         ack_a;
    eeprom_rsp_t  rsp_a;
    logic         wr_b;
    logic         rd_b;
    eeprom_addr_t addr_b;
    eeprom_byte_t wdata_b;
    logic         ack_b;
    eeprom_rsp_t  rsp_b;
    wire          scl;
    wire          sda;

    entry_t       tests[$];
    eeprom_byte_t shadow_mem [0:2047];
    int           errors;
    int           failed;
    int           cycles;
    int           cycle_limit = 0;
    integer       seed;
    logic         last_port;   // port granted last, for the round-robin turn

    pullup (sda);

    eeprom_subsystem #(
        .SCL_QUARTER (SCL_QUARTER)
    ) dut_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr_a    (wr_a),
        .rd_a    (rd_a),
        .addr_a  (addr_a),
        .wdata_a (wdata_a),
        .ack_a   (ack_a),
        .rsp_a   (rsp_a),
        .wr_b    (wr_b),
        .rd_b    (rd_b),
        .addr_b  (addr_b),
        .wdata_b (wdata_b),
        .ack_b   (ack_b),
        .rsp_b   (rsp_b),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model model_i (
        .scl (scl),
        .sda (sda)
    );

    always #5 CLK = ~CLK;

    task automatic add_entry(input logic port, input eeprom_op_e op, input eeprom_addr_t addr,
                             input eeprom_byte_t wdata, input logic simul,
                             input eeprom_byte_t exp_rdata, input logic exp_nack);
        tests.push_back('{port, op, addr, wdata, simul, 1'b0, exp_rdata, exp_nack});
    endtask

    task automatic add_random();
        entry_t e;
        integer r;
        r        = $random(seed);
        e        = '0;
        e.port   = r[0];
        e.op     = r[1] ? op_read : op_write;
        e.addr   = {r[4:2], 6'h2A, r[6:5]};   // small pool so reads meet earlier writes
        e.wdata  = r[14:7];
        e.shadow = 1'b1;
        tests.push_back(e);
    endtask

    task automatic drive_port(input entry_t e);
        if (e.port == 1'b0) begin
            wr_a    = (e.op == op_write);
            rd_a    = (e.op == op_read);
            addr_a  = e.addr;
            wdata_a = e.wdata;
        end else begin
            wr_b    = (e.op == op_write);
            rd_b    = (e.op == op_read);
            addr_b  = e.addr;
            wdata_b = e.wdata;
        end
    endtask

    task automatic clear_strobes();
        wr_a = 1'b0;
        rd_a = 1'b0;
        wr_b = 1'b0;
        rd_b = 1'b0;
    endtask

    task automatic wait_acks(input logic need_a, input logic need_b,
                             output eeprom_rsp_t got_a, output eeprom_rsp_t got_b,
                             output logic first_b);
        logic wait_a;
        logic wait_b;
        wait_a  = need_a;
        wait_b  = need_b;
        got_a   = '0;
        got_b   = '0;
        first_b = 1'b0;
        while (wait_a || wait_b) begin
            @(negedge CLK);   // acks settle after the rising edge
            if ((ack_a && !wait_a) || (ack_b && !wait_b)) begin
                $display("ack on a port with no request at %0t", $time);
                errors++;
            end
            if (ack_b && wait_b) begin
                got_b   = rsp_b;
                first_b = wait_a;
                wait_b  = 1'b0;
            end
            if (ack_a && wait_a) begin
                got_a  = rsp_a;
                wait_a = 1'b0;
            end
        end
    endtask

    task automatic compare_rdata(input eeprom_byte_t got, input eeprom_byte_t exp,
                                 input string tag);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s rdata %02h, expected %02h", $time, tag, got, exp);
            errors++;
        end
    endtask

    task automatic compare_nack(input logic got, input logic exp, input string tag);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s nack %b, expected %b", $time, tag, got, exp);
            errors++;
        end
    endtask

    task automatic check_entry(input int idx, input eeprom_rsp_t got);
        entry_t       e;
        eeprom_byte_t exp_rdata;
        logic         exp_nack;
        int           errs_before;
        string        tag;
        e           = tests[idx];
        errs_before = errors;
        exp_rdata   = e.exp_rdata;
        exp_nack    = e.exp_nack;
        if (e.shadow) begin
            exp_rdata = shadow_mem[e.addr];
            exp_nack  = (e.op == op_write) && (e.addr >= 11'h700);   // top page refuses data
        end
        tag = $sformatf("test %0d %s port %s addr %03h", idx, e.op.name(),
                        e.port ? "b" : "a", e.addr);
        if (e.op == op_read) begin
            compare_rdata(got.rdata, exp_rdata, tag);
        end
        compare_nack(got.nack, exp_nack, tag);
        if (e.op == op_write && e.addr < 11'h700) begin
            shadow_mem[e.addr] = e.wdata;
        end
        if (errors != errs_before) begin
            failed++;
        end
        $display("%s : %s", tag, (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        int          i;
        logic        pair;
        logic        need_a;
        logic        need_b;
        logic        first_b;
        eeprom_rsp_t got_a;
        eeprom_rsp_t got_b;
        CLK       = 1'b0;
        RESET     = 1'b1;
        addr_a    = '0;
        wdata_a   = '0;
        addr_b    = '0;
        wdata_b   = '0;
        clear_strobes();
        errors    = 0;
        failed    = 0;
        last_port = 1'b1;   // so port a wins the first tie
        seed      = 32'h9624_e183;
        for (int k = 0; k < 2048; k++) begin
            shadow_mem[k] = 8'hFF;
        end

        // port, op, addr, wdata, simul, exp rdata, exp nack
        add_entry(1'b0, op_write, 11'h100, 8'h11, 1'b1, 8'h00, 1'b0);
        add_entry(1'b1, op_write, 11'h200, 8'h22, 1'b0, 8'h00, 1'b0);
        add_entry(1'b0, op_read,  11'h200, 8'h00, 1'b1, 8'h22, 1'b0);
        add_entry(1'b1, op_read,  11'h100, 8'h00, 1'b0, 8'h11, 1'b0);
        add_entry(1'b0, op_write, 11'h012, 8'h5A, 1'b0, 8'h00, 1'b0);
        add_entry(1'b0, op_read,  11'h012, 8'h00, 1'b0, 8'h5A, 1'b0);
        add_entry(1'b1, op_write, 11'h034, 8'hC3, 1'b0, 8'h00, 1'b0);
        add_entry(1'b1, op_read,  11'h034, 8'h00, 1'b0, 8'hC3, 1'b0);
        add_entry(1'b0, op_write, 11'h056, 8'h81, 1'b0, 8'h00, 1'b0);
        add_entry(1'b1, op_read,  11'h056, 8'h00, 1'b0, 8'h81, 1'b0);
        add_entry(1'b0, op_write, 11'h7A0, 8'h33, 1'b0, 8'h00, 1'b1);
        add_entry(1'b1, op_read,  11'h7A0, 8'h00, 1'b0, 8'hFF, 1'b0);
        // same low byte, only the control byte bits differ
        add_entry(1'b0, op_write, 11'h0C5, 8'h10, 1'b0, 8'h00, 1'b0);
        add_entry(1'b1, op_write, 11'h1C5, 8'h21, 1'b0, 8'h00, 1'b0);
        add_entry(1'b0, op_write, 11'h3C5, 8'h43, 1'b0, 8'h00, 1'b0);
        add_entry(1'b1, op_write, 11'h6C5, 8'h76, 1'b0, 8'h00, 1'b0);
        add_entry(1'b0, op_read,  11'h6C5, 8'h00, 1'b0, 8'h76, 1'b0);
        add_entry(1'b1, op_read,  11'h3C5, 8'h00, 1'b0, 8'h43, 1'b0);
        add_entry(1'b0, op_read,  11'h1C5, 8'h00, 1'b0, 8'h21, 1'b0);
        add_entry(1'b1, op_read,  11'h0C5, 8'h00, 1'b0, 8'h10, 1'b0);
        for (int k = 0; k < N_RANDOM; k++) begin
            add_random();
        end
        // longest transfer per entry, then twice that again as margin
        cycle_limit = tests.size() * 39 * 4 * SCL_QUARTER * 3;

        repeat (10) @(negedge CLK);
        RESET = 1'b0;

        i = 0;
        while (i < tests.size()) begin
            pair = tests[i].simul;
            @(negedge CLK);
            drive_port(tests[i]);
            if (pair) begin
                drive_port(tests[i + 1]);
            end
            @(negedge CLK);
            clear_strobes();
            need_a = !tests[i].port || (pair && !tests[i + 1].port);
            need_b = tests[i].port || (pair && tests[i + 1].port);
            wait_acks(need_a, need_b, got_a, got_b, first_b);
            if (pair) begin
                if (first_b != !last_port) begin
                    $display("port %s was served first at %0t, its turn had not come",
                             first_b ? "b" : "a", $time);
                    errors++;
                end
                last_port = !first_b;   // the port served second
                check_entry(i, tests[i].port ? got_b : got_a);
                check_entry(i + 1, tests[i + 1].port ? got_b : got_a);
                i = i + 2;
            end else begin
                check_entry(i, tests[i].port ? got_b : got_a);
                last_port = tests[i].port;
                i = i + 1;
            end
        end

        if (dut_i.checker_i.fail_count != 0) begin
            $display("%0d bus or ack assertions failed during the run",
                     dut_i.checker_i.fail_count);
            errors = errors + dut_i.checker_i.fail_count;
        end
        $display("%0d tests, %0d failed, %0d errors", tests.size(), failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("run timed out after %0d cycles before all tests finished", cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== hdl/eeprom_bit_phy.sv ====
`timescale 1ns/1ns
module eeprom_bit_phy #(
    parameter int SCL_QUARTER = 2
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::bit_cmd_e cmd,
    input  logic                 tx_bit,
    output logic                 cmd_done,
    output logic                 rx_bit,
    output logic                 scl,
    output logic                 sda_drive_low,
    input  logic                 sda_in
);
    import eeprom_pkg::*;

    localparam int QW = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1;
    localparam logic [QW-1:0] Q_LAST = QW'(SCL_QUARTER - 1);

    bit_cmd_e      cmd_q;
    logic          tx_q;
    logic          busy;
    logic [1:0]    phase;
    logic [QW-1:0] qcnt;
    logic          q_end;

    // {scl, sda_drive_low} for one quarter of a symbol
    function automatic logic [1:0] wave(bit_cmd_e c, logic tx, logic [1:0] ph);
        logic scl_w;
        logic low_w;
        scl_w = (ph == 2'd1) || (ph == 2'd2);
        case (c)
            cmd_start: low_w = ph[1];   // sda falls in phase 2, scl high
            cmd_stop: begin
                low_w = (ph < 2'd2);    // sda rises in phase 2
                scl_w = (ph != 2'd0);   // and scl stays high afterwards
            end
            cmd_write: low_w = !tx;
            default:   low_w = 1'b0;    // read, bus released
        endcase
        return {scl_w, low_w};
    endfunction

    assign q_end = (qcnt == Q_LAST);

    // raised one cycle before the symbol ends so the engine can chain
    // the next symbol without a gap
    assign cmd_done = busy && ((SCL_QUARTER == 1) ? (phase == 2'd2)
                                                  : (phase == 2'd3 && qcnt == Q_LAST - 1'b1));

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy                 <= 1'b0;
            phase                <= 2'd0;
            qcnt                 <= '0;
            {scl, sda_drive_low} <= 2'b10;   // idle bus
        end else if (cmd_valid) begin
            busy                 <= 1'b1;
            phase                <= 2'd0;
            qcnt                 <= '0;
            {scl, sda_drive_low} <= wave(cmd, tx_bit, 2'd0);
        end else if (busy) begin
            if (q_end) begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                if (phase == 2'd3) begin
                    busy <= 1'b0;   // pins hold their last level
                end else begin
                    {scl, sda_drive_low} <= wave(cmd_q, tx_q, phase + 2'd1);
                end
            end else begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cmd_valid) begin
            cmd_q <= cmd;
            tx_q  <= tx_bit;
        end
        // middle of scl high
        if (busy && cmd_q == cmd_read && phase == 2'd1 && q_end) begin
            rx_bit <= sda_in;
        end
    end

endmodule

// ==== hdl/eeprom_bus_arbiter.sv ====
`timescale 1ns/1ns
module eeprom_bus_arbiter (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr_a,
    input  logic                     rd_a,
    input  eeprom_pkg::eeprom_addr_t addr_a,
    input  eeprom_pkg::eeprom_byte_t wdata_a,
    output logic                     ack_a,
    output eeprom_pkg::eeprom_rsp_t  rsp_a,
    input  logic                     wr_b,
    input  logic                     rd_b,
    input  eeprom_pkg::eeprom_addr_t addr_b,
    input  eeprom_pkg::eeprom_byte_t wdata_b,
    output logic                     ack_b,
    output eeprom_pkg::eeprom_rsp_t  rsp_b,
    input  logic                     engine_idle,
    output logic                     go,
    output eeprom_pkg::eeprom_req_t  req,
    input  logic                     done,
    input  eeprom_pkg::eeprom_rsp_t  rsp
);
    import eeprom_pkg::*;

    logic        pend_a;
    logic        pend_b;
    eeprom_req_t req_a;
    eeprom_req_t req_b;
    logic        last_b;   // also the owner of the running transfer
    logic        grant;
    logic        pick_b;

    // no new grant in the go cycle, engine_idle only drops after it
    assign grant  = engine_idle && !go && (pend_a || pend_b);
    assign pick_b = pend_b && (!pend_a || !last_b);

    assign ack_a = done && !last_b;
    assign ack_b = done && last_b;
    assign rsp_a = rsp;
    assign rsp_b = rsp;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pend_a <= 1'b0;
            pend_b <= 1'b0;
            last_b <= 1'b1;   // port a wins the first tie
            go     <= 1'b0;
        end else begin
            go <= grant;
            if (grant) begin
                last_b <= pick_b;
                if (pick_b) begin
                    pend_b <= 1'b0;
                end else begin
                    pend_a <= 1'b0;
                end
            end
            if (wr_a || rd_a) begin
                pend_a <= 1'b1;
            end
            if (wr_b || rd_b) begin
                pend_b <= 1'b1;
            end
        end
        // wr wins over rd in the same cycle
        if (wr_a || rd_a) begin
            req_a <= '{op: (wr_a ? op_write : op_read), addr: addr_a, wdata: wdata_a};
        end
        if (wr_b || rd_b) begin
            req_b <= '{op: (wr_b ? op_write : op_read), addr: addr_b, wdata: wdata_b};
        end
        if (grant) begin
            req <= pick_b ? req_b : req_a;
        end
    end

endmodule

// ==== hdl/eeprom_pkg.sv ====
package eeprom_pkg;

    // 2K byte device, upper three bits ride in the control byte
    typedef logic [10:0] eeprom_addr_t;
    typedef logic [7:0]  eeprom_byte_t;

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } eeprom_op_e;

    typedef struct packed {
        eeprom_op_e   op;
        eeprom_addr_t addr;
        eeprom_byte_t wdata;
    } eeprom_req_t;

    typedef struct packed {
        eeprom_byte_t rdata;
        logic         nack;   // slave refused a byte
    } eeprom_rsp_t;

    // bit level symbols between engine and phy
    typedef enum logic [1:0] {
        cmd_start = 2'd0,
        cmd_stop  = 2'd1,
        cmd_write = 2'd2,
        cmd_read  = 2'd3
    } bit_cmd_e;

    typedef enum logic [3:0] {
        st_idle    = 4'd0,
        st_start   = 4'd1,
        st_ctrl    = 4'd2,
        st_addr    = 4'd3,
        st_wdata   = 4'd4,
        st_restart = 4'd5,
        st_ctrl_rd = 4'd6,
        st_rdata   = 4'd7,
        st_stop    = 4'd8
    } txn_state_e;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage

// ==== hdl/eeprom_subsystem.sv ====
`timescale 1ns/1ns
module eeprom_subsystem #(
    parameter int SCL_QUARTER = 2
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr_a,
    input  logic                     rd_a,
    input  eeprom_pkg::eeprom_addr_t addr_a,
    input  eeprom_pkg::eeprom_byte_t wdata_a,
    output logic                     ack_a,
    output eeprom_pkg::eeprom_rsp_t  rsp_a,
    input  logic                     wr_b,
    input  logic                     rd_b,
    input  eeprom_pkg::eeprom_addr_t addr_b,
    input  eeprom_pkg::eeprom_byte_t wdata_b,
    output logic                     ack_b,
    output eeprom_pkg::eeprom_rsp_t  rsp_b,
    output logic                     scl,
    inout  wire                      sda
);
    import eeprom_pkg::*;

    logic        engine_idle;
    logic        go;
    logic        done;
    eeprom_req_t req;
    eeprom_rsp_t rsp;
    logic        cmd_valid;
    bit_cmd_e    cmd;
    logic        tx_bit;
    logic        cmd_done;
    logic        rx_bit;
    logic        sda_drive_low;

    // open drain, pull-up sits on the board
    assign sda = sda_drive_low ? 1'b0 : 1'bz;

    eeprom_bus_arbiter arbiter_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr_a        (wr_a),
        .rd_a        (rd_a),
        .addr_a      (addr_a),
        .wdata_a     (wdata_a),
        .ack_a       (ack_a),
        .rsp_a       (rsp_a),
        .wr_b        (wr_b),
        .rd_b        (rd_b),
        .addr_b      (addr_b),
        .wdata_b     (wdata_b),
        .ack_b       (ack_b),
        .rsp_b       (rsp_b),
        .engine_idle (engine_idle),
        .go          (go),
        .req         (req),
        .done        (done),
        .rsp         (rsp)
    );

    eeprom_txn_engine engine_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .go          (go),
        .req         (req),
        .engine_idle (engine_idle),
        .done        (done),
        .rsp         (rsp),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .tx_bit      (tx_bit),
        .cmd_done    (cmd_done),
        .rx_bit      (rx_bit)
    );

    eeprom_bit_phy #(
        .SCL_QUARTER (SCL_QUARTER)
    ) phy_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .tx_bit        (tx_bit),
        .cmd_done      (cmd_done),
        .rx_bit        (rx_bit),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)
    );

endmodule

// ==== hdl/eeprom_txn_engine.sv ====
`timescale 1ns/1ns
module eeprom_txn_engine (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    go,
    input  eeprom_pkg::eeprom_req_t req,
    output logic                    engine_idle,
    output logic                    done,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    cmd_valid,
    output eeprom_pkg::bit_cmd_e    cmd,
    output logic                    tx_bit,
    input  logic                    cmd_done,
    input  logic                    rx_bit
);
    import eeprom_pkg::*;

    txn_state_e   state;
    txn_state_e   state_n;
    logic [3:0]   bit_cnt;     // 0..7 data bits, 8 is the ack slot
    logic [3:0]   bit_cnt_n;
    logic         kick;        // first symbol after go
    logic         issue;
    eeprom_req_t  req_q;
    eeprom_byte_t rdata_n;
    logic         nack_n;
    eeprom_byte_t out_byte;
    logic         ack_slot;
    bit_cmd_e     sym_cmd;
    logic         sym_tx;

    assign engine_idle = (state == st_idle);
    assign ack_slot    = (bit_cnt == 4'd8);

    // next position in the sequence, advances once per finished symbol
    always_comb begin
        state_n   = state;
        bit_cnt_n = bit_cnt;
        rdata_n   = rsp.rdata;
        nack_n    = rsp.nack;
        if (state == st_idle) begin
            if (go) begin
                state_n   = st_start;
                bit_cnt_n = '0;
                nack_n    = 1'b0;
            end
        end else if (cmd_done) begin
            case (state)
                st_start:   state_n = st_ctrl;
                st_restart: state_n = st_ctrl_rd;
                st_stop:    state_n = st_idle;
                st_rdata: begin
                    if (ack_slot) begin
                        state_n = st_stop;
                    end else begin
                        rdata_n   = {rsp.rdata[6:0], rx_bit};   // msb first
                        bit_cnt_n = bit_cnt + 4'd1;
                    end
                end
                default: begin
                    if (!ack_slot) begin
                        bit_cnt_n = bit_cnt + 4'd1;
                    end else if (rx_bit) begin
                        state_n = st_stop;   // slave nack
                        nack_n  = 1'b1;
                    end else begin
                        bit_cnt_n = '0;
                        case (state)
                            st_ctrl:  state_n = st_addr;
                            st_addr:  state_n = (req_q.op == op_write) ? st_wdata : st_restart;
                            st_wdata: state_n = st_stop;
                            default:  state_n = st_rdata;
                        endcase
                    end
                end
            endcase
        end
    end

    // symbol for the position we move to
    always_comb begin
        case (state_n)
            st_ctrl:    out_byte = {DEVICE_CODE, req_q.addr[10:8], 1'b0};
            st_ctrl_rd: out_byte = {DEVICE_CODE, req_q.addr[10:8], 1'b1};
            st_addr:    out_byte = req_q.addr[7:0];
            default:    out_byte = req_q.wdata;
        endcase
        sym_tx = 1'b1;
        case (state_n)
            st_start, st_restart: sym_cmd = cmd_start;
            st_stop:              sym_cmd = cmd_stop;
            st_rdata: begin
                // ninth slot is the master nack, sym_tx stays 1
                sym_cmd = (bit_cnt_n == 4'd8) ? cmd_write : cmd_read;
            end
            default: begin
                sym_cmd = (bit_cnt_n == 4'd8) ? cmd_read : cmd_write;
                sym_tx  = out_byte[3'd7 - bit_cnt_n[2:0]];
            end
        endcase
    end

    assign issue = kick || (cmd_done && state_n != st_idle);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= st_idle;
            bit_cnt   <= '0;
            kick      <= 1'b0;
            cmd_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            state     <= state_n;
            bit_cnt   <= bit_cnt_n;
            kick      <= engine_idle && go;
            cmd_valid <= issue;
            done      <= cmd_done && (state == st_stop);
        end
        if (engine_idle && go) begin
            req_q <= req;
        end
        if (issue) begin
            cmd    <= sym_cmd;
            tx_bit <= sym_tx;
        end
        rsp <= '{rdata: rdata_n, nack: nack_n};
    end

endmodule
